// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_pc_gen.sv
      - rtl/fetch_align_buffer.sv
      - rtl/rvc_expander.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int          MEM_WORDS   = 256;
    localparam int          MAX_ENTRIES = 32;
    localparam logic [31:0] BASE        = `FETCH_RESET_PC;

    logic                   clk_i;
    logic                   rst_i;
    logic                   stall_i;
    logic                   flush_i;
    logic                   redirect_valid_i;
    logic [`FETCH_XLEN-1:0] redirect_pc_i;
    logic [31:0]            mem_data_i;
    logic                   mem_wait_i;
    logic [`FETCH_XLEN-1:0] mem_addr_o;
    decode_out_t            decode_out_o;
    logic                   instr_valid_o;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] prog_pc  [0:MAX_ENTRIES-1];
    logic        prog_c   [0:MAX_ENTRIES-1]; // compressed entry
    logic [31:0] prog_exp [0:MAX_ENTRIES-1]; // word decode must see
    int          prog_n;
    int          exp_idx;  // next table entry expected on a strobe
    int          exp_end;
    logic        rand_en;
    logic [31:0] rng_state;
    int          mismatch_errors;
    int          other_errors;
    int          assert_errors;

    fetch_top dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .mem_data_i       (mem_data_i),
        .mem_wait_i       (mem_wait_i),
        .mem_addr_o       (mem_addr_o),
        .decode_out_o     (decode_out_o),
        .instr_valid_o    (instr_valid_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ((addr ^ 32'h5a5a_a5a5) * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // combinational memory with the program window at the reset address
    assign mem_data_i = (mem_addr_o[31:10] == BASE[31:10]) ? mem[mem_addr_o[9:2]]
                                                            : fill_word(mem_addr_o);

    assert property (@(posedge clk_i) disable iff (rst_i) stall_i |-> !instr_valid_o)
        else begin
            $display("mismatch at %0t: instr_valid_o expected 0 got %b in a stalled cycle",
                     $time, $sampled(instr_valid_o));
            assert_errors++;
        end

    assert property (@(posedge clk_i) disable iff (rst_i) flush_i |=> !instr_valid_o)
        else begin
            $display("mismatch at %0t: instr_valid_o expected 0 got %b after flush",
                     $time, $sampled(instr_valid_o));
            assert_errors++;
        end

    assert property (@(posedge clk_i) disable iff (rst_i) flush_i |=> decode_out_o == '0)
        else begin
            $display("mismatch at %0t: decode_out_o expected 0 got %h after flush",
                     $time, $sampled(decode_out_o));
            assert_errors++;
        end

    assert property (@(posedge clk_i) rst_i |=> mem_addr_o == `FETCH_RESET_PC)
        else begin
            $display("mismatch at %0t: mem_addr_o expected %h got %h after reset",
                     $time, `FETCH_RESET_PC, $sampled(mem_addr_o));
            assert_errors++;
        end

    task automatic put_half(input logic [31:0] addr, input logic [15:0] half);
        if (addr[1]) begin
            mem[addr[9:2]][31:16] = half;
        end else begin
            mem[addr[9:2]][15:0] = half;
        end
    endtask

    task automatic add_word(input logic [31:0] offset, input logic [31:0] word);
        prog_pc[prog_n]  = BASE + offset;
        prog_c[prog_n]   = 1'b0;
        prog_exp[prog_n] = word;
        put_half(BASE + offset, word[15:0]);
        put_half(BASE + offset + 32'd2, word[31:16]); // may fall in the next word
        prog_n++;
    endtask

    task automatic add_comp(input logic [31:0] offset, input logic [15:0] half,
                            input logic [31:0] expansion);
        prog_pc[prog_n]  = BASE + offset;
        prog_c[prog_n]   = 1'b1;
        prog_exp[prog_n] = expansion;
        put_half(BASE + offset, half);
        prog_n++;
    endtask

    task automatic check_strobe();
        logic [31:0] size;
        // strobes in a redirect or flush cycle still belong to the old path
        if (!rst_i && instr_valid_o && !redirect_valid_i && !flush_i) begin
            if (exp_idx < exp_end) begin
                size = prog_c[exp_idx] ? 32'd2 : 32'd4;
                assert (decode_out_o.instr == prog_exp[exp_idx]) else begin
                    $display("mismatch at %0t: decode_out_o.instr expected %h got %h",
                             $time, prog_exp[exp_idx], decode_out_o.instr);
                    mismatch_errors++;
                end
                assert (decode_out_o.pc == prog_pc[exp_idx]) else begin
                    $display("mismatch at %0t: decode_out_o.pc expected %h got %h",
                             $time, prog_pc[exp_idx], decode_out_o.pc);
                    mismatch_errors++;
                end
                assert (decode_out_o.pc_next == prog_pc[exp_idx] + size) else begin
                    $display("mismatch at %0t: decode_out_o.pc_next expected %h got %h",
                             $time, prog_pc[exp_idx] + size, decode_out_o.pc_next);
                    mismatch_errors++;
                end
                exp_idx++;
            end else begin
                $display("unexpected instruction strobe at %0t for pc %h, none was expected",
                         $time, decode_out_o.pc);
                other_errors++;
            end
        end
    endtask

    // sample at the rising edge and drive at the falling edge
    task automatic run_cycle();
        @(posedge clk_i);
        check_strobe();
        @(negedge clk_i);
        redirect_valid_i = 1'b0;
        flush_i          = 1'b0;
        if (rand_en) begin
            rng_state  = xorshift32(rng_state);
            stall_i    = (rng_state[1:0] == 2'b00);
            mem_wait_i = (rng_state[5:4] == 2'b00);
        end else begin
            stall_i    = 1'b0;
            mem_wait_i = 1'b0;
        end
    endtask

    task automatic wait_for_entries(input int limit);
        int cycles;
        cycles = 0;
        while (exp_idx < exp_end && cycles < limit) begin
            run_cycle();
            cycles++;
        end
        if (exp_idx < exp_end) begin
            $display("timeout at %0t: entry %0d of %0d still missing after %0d cycles",
                     $time, exp_idx, exp_end, limit);
            other_errors++;
        end
    endtask

    // called at a falling edge and drops stall so the redirect is not lost
    task automatic redirect_to(input int first);
        stall_i          = 1'b0;
        mem_wait_i       = 1'b0;
        redirect_valid_i = 1'b1;
        redirect_pc_i    = prog_pc[first];
        exp_idx          = first;
        exp_end          = prog_n;
    endtask

    // one flush cycle on its own while the stream keeps taking instructions
    task automatic flush_output();
        stall_i    = 1'b0;
        mem_wait_i = 1'b0;
        flush_i    = 1'b1;
        run_cycle();
    endtask

    initial begin
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        stall_i          = 1'b0;
        flush_i          = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        mem_wait_i       = 1'b0;
        rand_en          = 1'b0;
        rng_state        = 32'hcb30;
        mismatch_errors  = 0;
        other_errors     = 0;
        assert_errors    = 0;
        prog_n           = 0;
        exp_idx          = 0;
        exp_end          = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(BASE + 32'(i) * 32'd4);
        end

        add_word(32'h00, 32'h0050_0093);               // addi x1, x0, 5
        add_comp(32'h04, 16'h451d, 32'h0070_0513);     // c.li x10, 7
        add_word(32'h06, 32'h0020_81b3);               // add x3, x1, x2 across words
        add_comp(32'h0a, 16'h85aa, 32'h00a0_05b3);     // c.mv x11, x10
        add_comp(32'h0c, 16'h1575, 32'hffd5_0513);     // c.addi x10, -3
        add_comp(32'h0e, 16'h4622, 32'h0081_2603);     // c.lwsp x12, 8
        add_word(32'h10, 32'h1234_52b7);               // lui x5, 0x12345
        add_comp(32'h14, 16'hc044, 32'h0094_2223);     // c.sw x9, 4(x8)
        add_comp(32'h16, 16'h8089, 32'h0024_d493);     // c.srli x9, 2
        add_comp(32'h18, 16'h8c65, 32'h0094_7433);     // c.and x8, x9
        add_word(32'h1a, 32'h0020_8463);               // beq x1, x2, 8 across words
        add_comp(32'h1e, 16'ha801, 32'h0100_006f);     // c.j 16
        add_word(32'h20, 32'h0ff3_4393);               // xori x7, x6, 0xff
        add_comp(32'h24, 16'h713d, 32'hfe01_0113);     // c.addi16sp -32
        add_comp(32'h26, 16'h0800, 32'h0101_0413);     // c.addi4spn x8, 16
        add_word(32'h28, 32'h4011_8233);               // sub x4, x3, x1
        add_comp(32'h2c, 16'he099, 32'h0004_9363);     // c.bnez x9, 6
        add_comp(32'h2e, 16'h8082, 32'h0000_8067);     // c.jr x1
        add_word(32'h30, 32'h0012_e333);               // or x6, x5, x1
        add_comp(32'h34, 16'h9002, 32'h0010_0073);     // c.ebreak
        add_comp(32'h36, 16'h0001, 32'h0000_0013);     // c.nop
        add_word(32'h38, 32'h0000_0013);

        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        @(posedge clk_i);
        assert (!instr_valid_o) else begin
            $display("mismatch at %0t: instr_valid_o expected 0 got %b", $time, instr_valid_o);
            mismatch_errors++;
        end
        assert (mem_addr_o == `FETCH_RESET_PC) else begin
            $display("mismatch at %0t: mem_addr_o expected %h got %h",
                     $time, `FETCH_RESET_PC, mem_addr_o);
            mismatch_errors++;
        end
        @(negedge clk_i);

        exp_idx = 0;
        exp_end = prog_n;
        wait_for_entries(100);  // clean stream from the reset address

        rand_en = 1'b1;
        redirect_to(0);
        wait_for_entries(600);  // same stream under wait and stall
        redirect_to(10);        // unaligned target with a straddling word
        wait_for_entries(400);

        rand_en = 1'b0;
        flush_output();         // drops the instruction taken past the table end
        redirect_to(2);
        wait_for_entries(100);

        $display("errors: %0d mismatch, %0d assertion, %0d other",
                 mismatch_errors, assert_errors, other_errors);
        if (mismatch_errors + assert_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// data and address width of the fetch stage
`define FETCH_XLEN 32

// first instruction after reset
`define FETCH_RESET_PC 32'h4000_0000

// RV32 major opcodes used by the compressed expansion
`define FETCH_OPC_OP     7'b0110011
`define FETCH_OPC_OP_IMM 7'b0010011
`define FETCH_OPC_LOAD   7'b0000011
`define FETCH_OPC_STORE  7'b0100011
`define FETCH_OPC_BRANCH 7'b1100011
`define FETCH_OPC_JAL    7'b1101111
`define FETCH_OPC_JALR   7'b1100111
`define FETCH_OPC_LUI    7'b0110111
`define FETCH_OPC_SYSTEM 7'b1110011

// implicit registers of the compressed forms
`define FETCH_REG_SP 5'd2 // stack pointer
`define FETCH_REG_RA 5'd1 // link register

`endif

// ==== rtl/fetch_align_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_align_buffer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   redirect_valid_i,
    input  logic [`FETCH_XLEN-1:0] pc_i,
    input  logic [31:0]            mem_data_i,
    input  logic                   mem_wait_i,
    output logic [`FETCH_XLEN-1:0] mem_addr_o,
    output fetch_pkg::raw_instr_t  raw_o,
    output logic                   take_o,
    output fetch_pkg::fetch_step_e step_o
);
    import fetch_pkg::*;

    localparam int TAG_W = `FETCH_XLEN - 2;

    logic [15:0]      half_q;       // upper halfword of a fetched word
    logic [TAG_W-1:0] tag_q;        // word address it came from
    logic             half_valid_q;

    logic [TAG_W-1:0] pc_word;
    logic [TAG_W-1:0] next_word;
    logic [TAG_W-1:0] fetch_word;
    logic [TAG_W-1:0] load_tag;
    logic             aligned;
    logic             hit;
    logic             go;
    logic             load_half;
    logic [15:0]      low_half;
    logic             is_compressed;

    assign pc_word   = pc_i[`FETCH_XLEN-1:2];
    assign next_word = pc_word + 1'b1;
    assign aligned   = ~pc_i[1];
    assign hit       = half_valid_q && (tag_q == pc_word);
    assign go        = ~stall_i & ~mem_wait_i & ~redirect_valid_i;

    // on a buffer hit the first half is already here, so fetch ahead
    assign fetch_word = (!aligned && hit) ? next_word : pc_word;
    assign mem_addr_o = {fetch_word, 2'b00};

    always_comb begin
        low_half      = aligned ? mem_data_i[15:0] : half_q;
        is_compressed = (low_half[1:0] != 2'b11);

        raw_o.pc         = pc_i;
        raw_o.compressed = is_compressed;
        if (is_compressed) begin
            raw_o.instr = {16'h0000, low_half};
        end else if (aligned) begin
            raw_o.instr = mem_data_i;
        end else begin
            raw_o.instr = {mem_data_i[15:0], half_q}; // straddles two words
        end
    end

    always_comb begin
        take_o    = 1'b0;
        step_o    = step_hold;
        load_half = 1'b0;
        load_tag  = pc_word;
        if (go) begin
            if (aligned) begin
                take_o    = 1'b1;
                step_o    = is_compressed ? step_half : step_word;
                load_half = is_compressed; // next pc lands on this upper half
            end else if (hit) begin
                take_o    = 1'b1;
                step_o    = is_compressed ? step_half : step_word;
                load_half = !is_compressed;
                load_tag  = next_word;
            end else begin
                load_half = 1'b1; // miss, fill and retry next cycle
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            half_valid_q <= 1'b0;
        end else if (!stall_i) begin
            if (redirect_valid_i) begin
                half_valid_q <= 1'b0;
            end else if (load_half) begin
                half_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_half) begin
            half_q <= mem_data_i[31:16];
            tag_q  <= load_tag;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_pc_gen (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   redirect_valid_i,
    input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
    input  fetch_pkg::fetch_step_e step_i,
    output logic [`FETCH_XLEN-1:0] pc_o
);
    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] pc_q;
    logic [`FETCH_XLEN-1:0] pc_step;
    logic [`FETCH_XLEN-1:0] pc_d;

    // advance by the size the buffer consumed
    always_comb begin
        case (step_i)
            step_half: pc_step = pc_q + `FETCH_XLEN'd2;
            step_word: pc_step = pc_q + `FETCH_XLEN'd4;
            default:   pc_step = pc_q;
        endcase
    end

    // execute wins over the sequential path
    always_comb begin
        if (redirect_valid_i) begin
            pc_d = {redirect_pc_i[`FETCH_XLEN-1:1], 1'b0}; // halfword resolution
        end else begin
            pc_d = pc_step;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // how far pc moves at the end of a cycle
    typedef enum logic [1:0] {
        step_hold = 2'd0, // no instruction consumed
        step_half = 2'd1, // compressed instruction, pc + 2
        step_word = 2'd2  // full instruction, pc + 4
    } fetch_step_e;

    // assembled instruction from the halfword buffer
    typedef struct packed {
        logic [31:0]             instr;      // upper half is zero when compressed
        logic                    compressed;
        logic [`FETCH_XLEN-1:0]  pc;
    } raw_instr_t;

    // registered instruction handed to decode
    typedef struct packed {
        logic [31:0]             instr;   // always the 32-bit form
        logic [`FETCH_XLEN-1:0]  pc;
        logic [`FETCH_XLEN-1:0]  pc_next; // fall-through address
    } decode_out_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   redirect_valid_i,
    input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
    input  logic [31:0]            mem_data_i,
    input  logic                   mem_wait_i,
    output logic [`FETCH_XLEN-1:0] mem_addr_o,
    output fetch_pkg::decode_out_t decode_out_o,
    output logic                   instr_valid_o
);
    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] pc;
    fetch_step_e            step;
    raw_instr_t             raw;
    logic                   take;

    fetch_pc_gen u_pc_gen (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .step_i           (step),
        .pc_o             (pc)
    );

    fetch_align_buffer u_align (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .pc_i             (pc),
        .mem_data_i       (mem_data_i),
        .mem_wait_i       (mem_wait_i),
        .mem_addr_o       (mem_addr_o),
        .raw_o            (raw),
        .take_o           (take),
        .step_o           (step)
    );

    rvc_expander u_expand (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .raw_i    (raw),
        .take_i   (take),
        .decode_o (decode_out_o),
        .valid_o  (instr_valid_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rvc_expander.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module rvc_expander (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  fetch_pkg::raw_instr_t  raw_i,
    input  logic                   take_i,
    output fetch_pkg::decode_out_t decode_o,
    output logic                   valid_o
);
    import fetch_pkg::*;

    logic [15:0]  c;
    logic [4:0]   rdp;   // rd' / rs2' field
    logic [4:0]   rs1p;  // rs1' / rd' field
    logic [20:0]  jimm;
    logic [12:0]  bimm;
    logic [11:0]  imm;
    logic [31:0]  expanded;
    logic [31:0]  instr;
    decode_out_t  decode_d;
    decode_out_t  decode_q;
    logic         valid_q;

    assign c    = raw_i.instr[15:0];
    assign rdp  = {2'b01, c[4:2]};
    assign rs1p = {2'b01, c[9:7]};
    assign jimm = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    assign bimm = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

    always_comb begin
        expanded = 32'h0000_0000; // outside the subset, decode sees illegal
        imm      = 12'h000;
        case ({c[15:13], c[1:0]})
            5'b000_00: begin // c.addi4spn
                imm = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
                if (c[12:5] != 8'h00) begin
                    expanded = {imm, `FETCH_REG_SP, 3'b000, rdp, `FETCH_OPC_OP_IMM};
                end
            end
            5'b010_00: begin // c.lw
                imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
                expanded = {imm, rs1p, 3'b010, rdp, `FETCH_OPC_LOAD};
            end
            5'b110_00: begin // c.sw
                imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
                expanded = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], `FETCH_OPC_STORE};
            end
            5'b000_01: begin // c.addi and c.nop
                expanded = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], `FETCH_OPC_OP_IMM};
            end
            5'b001_01: begin // c.jal links to ra
                expanded = {jimm[20], jimm[10:1], jimm[11], jimm[19:12],
                            `FETCH_REG_RA, `FETCH_OPC_JAL};
            end
            5'b010_01: begin // c.li
                expanded = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, c[11:7], `FETCH_OPC_OP_IMM};
            end
            5'b011_01: begin
                if (c[11:7] == `FETCH_REG_SP) begin // c.addi16sp
                    imm = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
                    expanded = {imm, `FETCH_REG_SP, 3'b000, `FETCH_REG_SP, `FETCH_OPC_OP_IMM};
                end else begin // c.lui
                    expanded = {{15{c[12]}}, c[6:2], c[11:7], `FETCH_OPC_LUI};
                end
            end
            5'b100_01: begin
                case (c[11:10])
                    2'b00: expanded = {7'b0000000, c[6:2], rs1p, 3'b101, rs1p, `FETCH_OPC_OP_IMM};
                    2'b01: expanded = {7'b0100000, c[6:2], rs1p, 3'b101, rs1p, `FETCH_OPC_OP_IMM};
                    2'b10: begin // c.andi
                        expanded = {{7{c[12]}}, c[6:2], rs1p, 3'b111, rs1p, `FETCH_OPC_OP_IMM};
                    end
                    default: begin
                        if (!c[12]) begin
                            case (c[6:5])
                                2'b00: expanded = {7'b0100000, rdp, rs1p, 3'b000, rs1p,
                                                   `FETCH_OPC_OP}; // c.sub
                                2'b01: expanded = {7'b0, rdp, rs1p, 3'b100, rs1p, `FETCH_OPC_OP};
                                2'b10: expanded = {7'b0, rdp, rs1p, 3'b110, rs1p, `FETCH_OPC_OP};
                                default: expanded = {7'b0, rdp, rs1p, 3'b111, rs1p, `FETCH_OPC_OP};
                            endcase
                        end
                    end
                endcase
            end
            5'b101_01: begin // c.j
                expanded = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd0, `FETCH_OPC_JAL};
            end
            5'b110_01, 5'b111_01: begin // c.beqz and c.bnez, funct3 from bit 13
                expanded = {bimm[12], bimm[10:5], 5'd0, rs1p, 2'b00, c[13],
                            bimm[4:1], bimm[11], `FETCH_OPC_BRANCH};
            end
            5'b000_10: begin // c.slli
                expanded = {7'b0000000, c[6:2], c[11:7], 3'b001, c[11:7], `FETCH_OPC_OP_IMM};
            end
            5'b010_10: begin // c.lwsp
                imm = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
                expanded = {imm, `FETCH_REG_SP, 3'b010, c[11:7], `FETCH_OPC_LOAD};
            end
            5'b100_10: begin
                if (!c[12]) begin
                    if (c[6:2] == 5'd0) begin // c.jr
                        expanded = {12'h000, c[11:7], 3'b000, 5'd0, `FETCH_OPC_JALR};
                    end else begin // c.mv
                        expanded = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], `FETCH_OPC_OP};
                    end
                end else if (c[6:2] == 5'd0) begin
                    if (c[11:7] == 5'd0) begin // c.ebreak
                        expanded = {12'h001, 5'd0, 3'b000, 5'd0, `FETCH_OPC_SYSTEM};
                    end else begin // c.jalr
                        expanded = {12'h000, c[11:7], 3'b000, `FETCH_REG_RA, `FETCH_OPC_JALR};
                    end
                end else begin // c.add
                    expanded = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], `FETCH_OPC_OP};
                end
            end
            5'b110_10: begin // c.swsp
                imm = {4'b0, c[8:7], c[12:9], 2'b00};
                expanded = {imm[11:5], c[6:2], `FETCH_REG_SP, 3'b010, imm[4:0], `FETCH_OPC_STORE};
            end
            default: expanded = 32'h0000_0000;
        endcase
    end

    assign instr = raw_i.compressed ? expanded : raw_i.instr;

    always_comb begin
        decode_d.instr   = instr;
        decode_d.pc      = raw_i.pc;
        decode_d.pc_next = raw_i.pc + (raw_i.compressed ? `FETCH_XLEN'd2 : `FETCH_XLEN'd4);
    end

    // flush must not wait for a stall to clear
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            decode_q <= '0;
            valid_q  <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= take_i;
            if (take_i) begin
                decode_q <= decode_d;
            end
        end
    end

    assign decode_o = decode_q;
    assign valid_o  = valid_q & ~stall_i; // held entry strobes once, after the stall

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_align_buffer.sv
rtl/rvc_expander.sv
rtl/fetch_top.sv
dv/fetch_tb.sv
